// ==== source/fpu_pkg.sv ====
package fpu_pkg;

  // packed SIMD data, two singles per word
  localparam int DATA_W = 64;
  localparam int HALF_W = DATA_W / 2;

  // forwarding buses seen by each lane
  localparam int NUM_EXT_FWD = 4;
  localparam int NUM_FWD = NUM_EXT_FWD + 2;

  // exception flags and their enables in the control register
  localparam int FLAG_W = 11;
  localparam int EXC_EN_LSB = 11;
  localparam int FLAG_INVALID = 0;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [FLAG_W-1:0] flags_t;
  typedef logic [31:0] csr_t;

  // 0 = nothing enabled was raised, else lowest enabled flag + 1
  typedef logic [3:0] ret_t;

  typedef logic [NUM_FWD-1:0] fwd_sel_t;

  typedef enum logic [3:0] {
    OP_AND    = 4'd0,
    OP_OR     = 4'd1,
    OP_XOR    = 4'd2,
    OP_ANDN   = 4'd3,
    OP_SWAP   = 4'd4,
    OP_DUP_LO = 4'd5,
    OP_MERGE  = 4'd6
  } fpu_op_e;

  // logic function select
  localparam logic [1:0] LSEL_AND  = 2'd0;
  localparam logic [1:0] LSEL_OR   = 2'd1;
  localparam logic [1:0] LSEL_XOR  = 2'd2;
  localparam logic [1:0] LSEL_ANDN = 2'd3;

  // half-lane permute modes
  localparam logic [1:0] PERM_SWAP   = 2'd0;
  localparam logic [1:0] PERM_DUP_LO = 2'd1;
  localparam logic [1:0] PERM_MERGE  = 2'd2;

  typedef struct packed {
    logic       is_logic;
    logic [1:0] logic_sel;
    logic [1:0] perm_mode;
    logic       undefined;
  } exec_ctrl_t;

  // one lane's issue as presented by the scheduler
  typedef struct packed {
    fpu_op_e  op;
    data_t    reg_a;
    data_t    reg_b;
    fwd_sel_t fwd_a;
    fwd_sel_t late_a;
    fwd_sel_t fwd_b;
    fwd_sel_t late_b;
    flags_t   raise;
  } issue_t;

endpackage

// ==== source/operand_forward.sv ====
`timescale 1ns/10ps

module operand_forward #(
  parameter int DATA_W  = fpu_pkg::DATA_W,
  parameter int NUM_FWD = fpu_pkg::NUM_FWD
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [DATA_W-1:0]              reg_val,
  input  logic [NUM_FWD-1:0]             fwd,
  input  logic [NUM_FWD-1:0]             late,
  input  logic [NUM_FWD-1:0][DATA_W-1:0] fwd_bus,
  output logic [DATA_W-1:0]              operand
);

  // bus values as they were one cycle ago
  logic [NUM_FWD-1:0][DATA_W-1:0] bus_q;

  always_ff @(posedge clk) begin
    bus_q <= fwd_bus;
  end

  // register value unless a bus is selected
  always_comb begin
    operand = reg_val;
    for (int i = 0; i < NUM_FWD; i++) begin
      if (late[i]) begin
        operand = bus_q[i];
      end
    end
    // a same-cycle select wins over a late one
    for (int i = 0; i < NUM_FWD; i++) begin
      if (fwd[i]) begin
        operand = fwd_bus[i];
      end
    end
  end

  // scheduler must never point one operand at two sources
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({fwd, late})
  );

endmodule

// ==== source/fpu_decode.sv ====
`timescale 1ns/10ps

module fpu_decode import fpu_pkg::*; (
  input  fpu_op_e    op,
  output exec_ctrl_t ctrl
);

  always_comb begin
    ctrl = '0;
    case (op)
      // bitwise group
      OP_AND: begin
        ctrl.is_logic  = 1'b1;
        ctrl.logic_sel = LSEL_AND;
      end
      OP_OR: begin
        ctrl.is_logic  = 1'b1;
        ctrl.logic_sel = LSEL_OR;
      end
      OP_XOR: begin
        ctrl.is_logic  = 1'b1;
        ctrl.logic_sel = LSEL_XOR;
      end
      OP_ANDN: begin
        ctrl.is_logic  = 1'b1;
        ctrl.logic_sel = LSEL_ANDN;
      end
      // half-lane permutes
      OP_SWAP: begin
        ctrl.perm_mode = PERM_SWAP;
      end
      OP_DUP_LO: begin
        ctrl.perm_mode = PERM_DUP_LO;
      end
      OP_MERGE: begin
        ctrl.perm_mode = PERM_MERGE;
      end
      default: begin
        ctrl.undefined = 1'b1;
      end
    endcase
  end

endmodule

// ==== source/simd_execute.sv ====
`timescale 1ns/10ps

module simd_execute import fpu_pkg::*; #(
  parameter int DATA_W = fpu_pkg::DATA_W
) (
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  exec_ctrl_t        ctrl,
  output logic [DATA_W-1:0] result
);

  localparam int HALF_W = DATA_W / 2;

  logic [HALF_W-1:0] a_lo;
  logic [HALF_W-1:0] a_hi;
  logic [HALF_W-1:0] b_lo;
  logic [DATA_W-1:0] logic_res;
  logic [DATA_W-1:0] perm_res;

  assign a_lo = a[HALF_W-1:0];
  assign a_hi = a[DATA_W-1:HALF_W];
  assign b_lo = b[HALF_W-1:0];

  always_comb begin
    case (ctrl.logic_sel)
      LSEL_AND:  logic_res = a & b;
      LSEL_OR:   logic_res = a | b;
      LSEL_XOR:  logic_res = a ^ b;
      default:   logic_res = a & ~b;
    endcase
  end

  // singles move as whole halves
  always_comb begin
    case (ctrl.perm_mode)
      PERM_SWAP:   perm_res = {a_lo, a_hi};
      PERM_DUP_LO: perm_res = {b_lo, b_lo};
      PERM_MERGE:  perm_res = {a_hi, b_lo};
      default:     perm_res = '0;
    endcase
  end

  always_comb begin
    if (ctrl.undefined) begin
      result = '0;
    end else if (ctrl.is_logic) begin
      result = logic_res;
    end else begin
      result = perm_res;
    end
  end

endmodule

// ==== source/fp_except.sv ====
`timescale 1ns/10ps

module fp_except import fpu_pkg::*; (
  input  flags_t raise,
  input  logic   undefined,
  input  csr_t   csr,
  output ret_t   code
);

  flags_t raised;
  flags_t enabled;

  // an undefined opcode counts as an invalid operation
  always_comb begin
    raised = raise;
    raised[FLAG_INVALID] = raise[FLAG_INVALID] | undefined;
  end

  assign enabled = raised & csr[EXC_EN_LSB +: FLAG_W];

  // lowest enabled flag wins
  always_comb begin
    code = '0;
    for (int i = FLAG_W - 1; i >= 0; i--) begin
      if (enabled[i]) begin
        code = ret_t'(i + 1);
      end
    end
  end

endmodule

// ==== source/fpu_lane.sv ====
`timescale 1ns/10ps

module fpu_lane import fpu_pkg::*; #(
  parameter int DATA_W  = fpu_pkg::DATA_W,
  parameter int NUM_FWD = fpu_pkg::NUM_FWD
) (
  input  logic                           clk,
  input  logic                           rst,
  input  csr_t                           csr,
  input  issue_t                         issue,
  input  logic                           issue_en,
  input  logic [NUM_FWD-1:0][DATA_W-1:0] fwd_bus,
  output logic [DATA_W-1:0]              result,
  output logic                           done,
  output ret_t                           ret
);

  logic [DATA_W-1:0] opa;
  logic [DATA_W-1:0] opb;
  logic [DATA_W-1:0] opa_q;
  logic [DATA_W-1:0] opb_q;
  logic [DATA_W-1:0] exe_res;
  exec_ctrl_t        ctrl;
  exec_ctrl_t        ctrl_q;
  flags_t            raise_q;
  logic              valid_q;
  ret_t              code;

  operand_forward #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) u_fwd_a (
    .clk     (clk),
    .rst     (rst),
    .reg_val (issue.reg_a),
    .fwd     (issue.fwd_a),
    .late    (issue.late_a),
    .fwd_bus (fwd_bus),
    .operand (opa)
  );

  operand_forward #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) u_fwd_b (
    .clk     (clk),
    .rst     (rst),
    .reg_val (issue.reg_b),
    .fwd     (issue.fwd_b),
    .late    (issue.late_b),
    .fwd_bus (fwd_bus),
    .operand (opb)
  );

  fpu_decode u_decode (
    .op   (issue.op),
    .ctrl (ctrl)
  );

  // issue stage
  always_ff @(posedge clk) begin
    opa_q   <= opa;
    opb_q   <= opb;
    ctrl_q  <= ctrl;
    raise_q <= issue.raise;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_en;
    end
  end

  simd_execute #(.DATA_W(DATA_W)) u_execute (
    .a      (opa_q),
    .b      (opb_q),
    .ctrl   (ctrl_q),
    .result (exe_res)
  );

  fp_except u_except (
    .raise     (raise_q),
    .undefined (ctrl_q.undefined),
    .csr       (csr),
    .code      (code)
  );

  // completion stage
  // result also feeds the lane's forwarding bus
  always_ff @(posedge clk) begin
    if (rst) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= valid_q;
      if (valid_q) begin
        result <= exe_res;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_q) begin
      ret <= code;
    end
  end

  // nothing can be in flight out of reset
  a_no_done_after_rst: assert property (
    @(posedge clk) (rst || $past(rst)) |=> !done
  );

endmodule

// ==== source/fpu_cluster.sv ====
`timescale 1ns/10ps

module fpu_cluster import fpu_pkg::*; #(
  parameter int DATA_W  = fpu_pkg::DATA_W,
  parameter int NUM_FWD = fpu_pkg::NUM_FWD
) (
  input  logic                           clk,
  input  logic                           rst,
  input  csr_t                           csr,
  input  issue_t                         issue0,
  input  issue_t                         issue1,
  input  logic                           issue_en0,
  input  logic                           issue_en1,
  input  logic [NUM_FWD-3:0][DATA_W-1:0] ext_fwd,
  output logic [DATA_W-1:0]              result0,
  output logic [DATA_W-1:0]              result1,
  output logic                           done0,
  output logic                           done1,
  output ret_t                           ret0,
  output ret_t                           ret1
);

  // external buses low, then lane 0, then lane 1
  logic [NUM_FWD-1:0][DATA_W-1:0] fwd_bus;

  assign fwd_bus = {result1, result0, ext_fwd};

  fpu_lane #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) u_lane0 (
    .clk      (clk),
    .rst      (rst),
    .csr      (csr),
    .issue    (issue0),
    .issue_en (issue_en0),
    .fwd_bus  (fwd_bus),
    .result   (result0),
    .done     (done0),
    .ret      (ret0)
  );

  fpu_lane #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) u_lane1 (
    .clk      (clk),
    .rst      (rst),
    .csr      (csr),
    .issue    (issue1),
    .issue_en (issue_en1),
    .fwd_bus  (fwd_bus),
    .result   (result1),
    .done     (done1),
    .ret      (ret1)
  );

endmodule

// ==== testbench/fpu_tests.svh ====
// idle after reset
task automatic test_reset();
  for (int i = 0; i < 8; i++) begin
    @(negedge clk);
    checks++;
    if (done0 || done1) begin
      $display("reset: done went high with nothing issued");
      errors++;
    end
    if (result0 !== '0) begin
      $display("error reset result0: expected %h, actual %h", data_t'(0), result0);
      errors++;
    end
    if (result1 !== '0) begin
      $display("error reset result1: expected %h, actual %h", data_t'(0), result1);
      errors++;
    end
  end
endtask

task automatic test_logic();
  fpu_op_e ops[4];
  issue_t  iss;
  data_t   r;
  ops = '{OP_AND, OP_OR, OP_XOR, OP_ANDN};
  csr = '0;
  for (int lane = 0; lane < 2; lane++) begin
    for (int k = 0; k < 4; k++) begin
      iss = make_issue(ops[k], random_data(), random_data(), '0);
      run_op($sformatf("logic_%s_lane%0d", ops[k].name(), lane), lane, iss,
             iss.reg_a, iss.reg_b, r);
    end
  end
endtask

task automatic test_permute();
  fpu_op_e ops[3];
  issue_t  iss;
  data_t   r;
  ops = '{OP_SWAP, OP_DUP_LO, OP_MERGE};
  csr = '0;
  for (int lane = 0; lane < 2; lane++) begin
    for (int k = 0; k < 3; k++) begin
      iss = make_issue(ops[k], random_data(), random_data(), '0);
      run_op($sformatf("perm_%s_lane%0d", ops[k].name(), lane), lane, iss,
             iss.reg_a, iss.reg_b, r);
    end
  end
endtask

task automatic test_forwarding();
  issue_t iss;
  data_t  fwd_val;
  data_t  old_val;
  data_t  r0;
  data_t  r1;
  data_t  r;
  csr = '0;
  // external bus, same cycle
  fwd_val = random_data();
  ext_fwd[2] = fwd_val;
  iss = make_issue(OP_OR, random_data(), random_data(), '0);
  iss.fwd_a[2] = 1'b1;
  run_op("fwd_ext_now", 1, iss, fwd_val, iss.reg_b, r);
  // external bus, one cycle late
  old_val = random_data();
  ext_fwd[1] = old_val;
  @(negedge clk);
  ext_fwd[1] = random_data();
  iss = make_issue(OP_XOR, random_data(), random_data(), '0);
  iss.late_b[1] = 1'b1;
  run_op("fwd_ext_late", 0, iss, iss.reg_a, old_val, r);
  // lane 0 chained on its own bus
  iss = make_issue(OP_XOR, random_data(), random_data(), '0);
  run_op("chain_first", 0, iss, iss.reg_a, iss.reg_b, r0);
  iss = make_issue(OP_AND, random_data(), random_data(), '0);
  iss.fwd_a[NUM_EXT_FWD] = 1'b1;
  run_op("chain_second", 0, iss, r0, iss.reg_b, r1);
  iss = make_issue(OP_MERGE, random_data(), random_data(), '0);
  iss.fwd_b[NUM_EXT_FWD] = 1'b1;
  run_op("chain_third", 0, iss, iss.reg_a, r1, r);
  // lane 1 takes lane 0's bus late, then its own bus
  iss = make_issue(OP_ANDN, random_data(), random_data(), '0);
  iss.late_a[NUM_EXT_FWD] = 1'b1;
  run_op("cross_lane_late", 1, iss, r, iss.reg_b, r1);
  iss = make_issue(OP_DUP_LO, random_data(), random_data(), '0);
  iss.fwd_b[NUM_EXT_FWD + 1] = 1'b1;
  run_op("lane1_own_bus", 1, iss, iss.reg_a, r1, r);
endtask

task automatic test_exceptions();
  issue_t iss;
  data_t  r;
  csr = '0;
  csr[EXC_EN_LSB +: FLAG_W] = '1;
  iss = make_issue(OP_OR, random_data(), random_data(), flags_t'(11'h028));
  run_op("exc_all_enabled", 0, iss, iss.reg_a, iss.reg_b, r);
  csr[EXC_EN_LSB + 3] = 1'b0;
  run_op("exc_low_masked", 1, iss, iss.reg_a, iss.reg_b, r);
  csr = '0;
  run_op("exc_none_enabled", 0, iss, iss.reg_a, iss.reg_b, r);
  for (int k = 0; k < 6; k++) begin
    csr = $random(seed);
    iss = make_issue(random_op(), random_data(), random_data(), flags_t'($random(seed)));
    run_op($sformatf("exc_random%0d", k), k % 2, iss, iss.reg_a, iss.reg_b, r);
  end
endtask

task automatic test_undefined();
  issue_t iss;
  data_t  r;
  csr = '0;
  csr[EXC_EN_LSB + FLAG_INVALID] = 1'b1;
  iss = make_issue(fpu_op_e'(4'd9), random_data(), random_data(), '0);
  run_op("undef_op9_lane0", 0, iss, iss.reg_a, iss.reg_b, r);
  iss = make_issue(fpu_op_e'(4'd15), random_data(), random_data(), '0);
  run_op("undef_op15_lane1", 1, iss, iss.reg_a, iss.reg_b, r);
  // invalid raised but masked, next flag shows
  csr = '0;
  csr[EXC_EN_LSB + 2] = 1'b1;
  iss = make_issue(fpu_op_e'(4'd7), random_data(), random_data(), flags_t'(11'h004));
  run_op("undef_invalid_masked", 0, iss, iss.reg_a, iss.reg_b, r);
endtask

// latency is fixed, so item i completes two negedges after its issue
task automatic test_pipeline();
  issue_t iss0[8];
  issue_t iss1[8];
  data_t  exp0[8];
  data_t  exp1[8];
  csr = '0;
  for (int i = 0; i < 8; i++) begin
    iss0[i] = make_issue(random_op(), random_data(), random_data(), '0);
    iss1[i] = make_issue(random_op(), random_data(), random_data(), '0);
    exp0[i] = model_result(iss0[i].op, iss0[i].reg_a, iss0[i].reg_b);
    exp1[i] = model_result(iss1[i].op, iss1[i].reg_a, iss1[i].reg_b);
  end
  for (int i = 0; i < 10; i++) begin
    if (i >= 2) begin
      checks++;
      if (!done0 || !done1) begin
        $display("pipeline: a lane missed its completion for item %0d", i - 2);
        errors++;
      end
      if (result0 !== exp0[i-2]) begin
        $display("error pipeline_lane0_item%0d: expected %h, actual %h",
                 i - 2, exp0[i-2], result0);
        errors++;
      end
      if (result1 !== exp1[i-2]) begin
        $display("error pipeline_lane1_item%0d: expected %h, actual %h",
                 i - 2, exp1[i-2], result1);
        errors++;
      end
    end
    if (i < 8) begin
      issue0 = iss0[i];
      issue1 = iss1[i];
      issue_en0 = 1'b1;
      issue_en1 = 1'b1;
    end else begin
      issue_en0 = 1'b0;
      issue_en1 = 1'b0;
    end
    @(negedge clk);
  end
  checks++;
  if (done0 || done1) begin
    $display("pipeline: done still high after the last completion");
    errors++;
  end
endtask

// ==== testbench/tb_fpu_cluster.sv ====
`timescale 1ns/10ps

module tb_fpu_cluster import fpu_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  // reset, idle check, about 40 single issues of 4 cycles, pipelined burst
  localparam int RUN_CYCLES = RESET_CYCLES + 8 + 40 * 4 + 12;

  logic   clk;
  logic   rst;
  csr_t   csr;
  issue_t issue0;
  issue_t issue1;
  logic   issue_en0;
  logic   issue_en1;
  logic [NUM_EXT_FWD-1:0][DATA_W-1:0] ext_fwd;
  data_t  result0;
  data_t  result1;
  logic   done0;
  logic   done1;
  ret_t   ret0;
  ret_t   ret1;

  int errors;
  int checks;
  int seed;

  fpu_cluster #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) DUT (
    .clk       (clk),
    .rst       (rst),
    .csr       (csr),
    .issue0    (issue0),
    .issue1    (issue1),
    .issue_en0 (issue_en0),
    .issue_en1 (issue_en1),
    .ext_fwd   (ext_fwd),
    .result0   (result0),
    .result1   (result1),
    .done0     (done0),
    .done1     (done1),
    .ret0      (ret0),
    .ret1      (ret1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // opcode table
  function automatic data_t model_result(fpu_op_e op, data_t a, data_t b);
    case (op)
      OP_AND:    return a & b;
      OP_OR:     return a | b;
      OP_XOR:    return a ^ b;
      OP_ANDN:   return a & ~b;
      OP_SWAP:   return {a[HALF_W-1:0], a[DATA_W-1:HALF_W]};
      OP_DUP_LO: return {b[HALF_W-1:0], b[HALF_W-1:0]};
      OP_MERGE:  return {a[DATA_W-1:HALF_W], b[HALF_W-1:0]};
      default:   return '0;
    endcase
  endfunction

  function automatic logic is_undefined(fpu_op_e op);
    case (op)
      OP_AND, OP_OR, OP_XOR, OP_ANDN, OP_SWAP, OP_DUP_LO, OP_MERGE: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  // lowest enabled raised flag plus one, zero if none
  function automatic ret_t model_ret(flags_t raise, logic undef, csr_t c);
    flags_t act;
    ret_t   r;
    logic   found;
    act = raise;
    if (undef) begin
      act[FLAG_INVALID] = 1'b1;
    end
    r = '0;
    found = 1'b0;
    for (int i = 0; i < FLAG_W; i++) begin
      if (!found && act[i] && c[EXC_EN_LSB + i]) begin
        r = ret_t'(i + 1);
        found = 1'b1;
      end
    end
    return r;
  endfunction

  function automatic issue_t make_issue(fpu_op_e op, data_t a, data_t b, flags_t raise);
    issue_t iss;
    iss = '0;
    iss.op = op;
    iss.reg_a = a;
    iss.reg_b = b;
    iss.raise = raise;
    return iss;
  endfunction

  function automatic data_t random_data();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic fpu_op_e random_op();
    return fpu_op_e'(4'($unsigned($random(seed)) % 7));
  endfunction

  // issue one op on a lane and check its single completion
  task automatic run_op(input string name, input int lane, input issue_t iss,
                        input data_t a_exp, input data_t b_exp, output data_t res_exp);
    ret_t  ret_exp;
    data_t res_got;
    ret_t  ret_got;
    logic  done_got;
    int    cycles;
    res_exp = model_result(iss.op, a_exp, b_exp);
    ret_exp = model_ret(iss.raise, is_undefined(iss.op), csr);
    if (lane == 0) begin
      issue0 = iss;
      issue_en0 = 1'b1;
    end else begin
      issue1 = iss;
      issue_en1 = 1'b1;
    end
    @(negedge clk);
    issue_en0 = 1'b0;
    issue_en1 = 1'b0;
    cycles = 1;
    done_got = (lane == 0) ? done0 : done1;
    while (!done_got && cycles < 8) begin
      @(negedge clk);
      cycles++;
      done_got = (lane == 0) ? done0 : done1;
    end
    checks++;
    if (!done_got) begin
      $display("%s: lane %0d gave no done pulse within 8 cycles", name, lane);
      errors++;
    end else begin
      res_got = (lane == 0) ? result0 : result1;
      ret_got = (lane == 0) ? ret0 : ret1;
      if (cycles != 2) begin
        $display("error %s latency: expected %0d, actual %0d", name, 2, cycles);
        errors++;
      end
      if (res_got !== res_exp) begin
        $display("error %s result: expected %h, actual %h", name, res_exp, res_got);
        errors++;
      end
      if (ret_got !== ret_exp) begin
        $display("error %s ret: expected %0d, actual %0d", name, ret_exp, ret_got);
        errors++;
      end
      @(negedge clk);
      done_got = (lane == 0) ? done0 : done1;
      if (done_got) begin
        $display("%s: done on lane %0d stayed high for more than one cycle", name, lane);
        errors++;
      end
    end
  endtask

  `include "fpu_tests.svh"

  initial begin
    #(RUN_CYCLES * CLK_PERIOD * 2);
    $display("timeout: the tests did not finish in %0d cycles", RUN_CYCLES * 2);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    seed = 85;
    errors = 0;
    checks = 0;
    rst = 1'b1;
    csr = '0;
    issue0 = '0;
    issue1 = '0;
    issue_en0 = 1'b0;
    issue_en1 = 1'b0;
    ext_fwd = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_logic();
    test_permute();
    test_forwarding();
    test_exceptions();
    test_undefined();
    test_pipeline();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== fpu_cluster.f ====
+incdir+testbench
source/fpu_pkg.sv
source/operand_forward.sv
source/fpu_decode.sv
source/simd_execute.sv
source/fp_except.sv
source/fpu_lane.sv
source/fpu_cluster.sv
testbench/tb_fpu_cluster.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_fpu_cluster \
  -f fpu_cluster.f -o sim_fpu_cluster &&
./obj_dir/sim_fpu_cluster | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null &&
echo "fpu_cluster: run passed" ||
{ echo "fpu_cluster: run failed"; exit 1; }
